//--- gpio_consts.svh
// GPIO block constants for pin counts, Wishbone widths and register offsets
`ifndef GPIO_CONSTS_SVH
`define GPIO_CONSTS_SVH

// ************************************************************
// Pin counts
// ************************************************************
// Output pins driven from the OUT register
`define GPIO_OUT_W 16
// Input pins seen through IN and CHANGE
`define GPIO_IN_W 16

// Wishbone byte address and data widths
`define GPIO_ADR_W 4
`define GPIO_DAT_W 32

// Register byte offsets on word boundaries
`define GPIO_OFS_OUT    4'h0
`define GPIO_OFS_IN     4'h4
`define GPIO_OFS_CHANGE 4'h8
`define GPIO_OFS_IRQ_EN 4'hC
`endif

//--- gpio_bus_pkg.sv
// Wishbone address and data types with the GPIO register select encoding
`include "gpio_consts.svh"

package gpio_bus_pkg;

	// ************************************************************
	// Bus word types
	// ************************************************************
	// Byte address seen on the slave port
	typedef logic [`GPIO_ADR_W-1:0] wb_adr_t;

	// Full 32-bit data word with no byte lanes
	typedef logic [`GPIO_DAT_W-1:0] wb_dat_t;

	// ************************************************************
	// Register select
	// ************************************************************
	// Word index taken from address bits 3 to 2
	// Values follow the byte offsets divided by four
	typedef enum logic [1:0]
	{
		REG_OUT    = 2'(`GPIO_OFS_OUT >> 2),
		REG_IN     = 2'(`GPIO_OFS_IN >> 2),
		REG_CHANGE = 2'(`GPIO_OFS_CHANGE >> 2),
		REG_IRQ_EN = 2'(`GPIO_OFS_IRQ_EN >> 2)
	} gpio_reg_e;

endpackage

//--- gpio_io_pkg.sv
// Pin vector types for the GPIO output and input sides
`include "gpio_consts.svh"

package gpio_io_pkg;

	// Output pin vector as held in OUT
	typedef logic [`GPIO_OUT_W-1:0] gpio_out_t;

	// Input pin vector
	// Also the shape of the synchronized value
	// and of the sticky change flags and masks
	typedef logic [`GPIO_IN_W-1:0] gpio_in_t;

	// Widths must fit one bus word
	// Upper read bits are zero filled

endpackage

//--- gpio_status_if.sv
// Link between input capture and bus slave for pin state, change flags and clears
interface gpio_status_if
	import gpio_io_pkg::*;
();
	// Pins after the two-stage synchronizer
	gpio_in_t in_value;
	// Sticky change flags
	gpio_in_t change;
	// Bits to clear when the strobe is high
	gpio_in_t clear_mask;
	// One-cycle clear strobe from a CHANGE write
	logic     clear;

	// Capture side owns pin state and flags
	modport capture
	(
		output in_value,
		output change,
		input  clear_mask,
		input  clear
	);

	// Bus side reads state and requests clears
	modport host
	(
		input  in_value,
		input  change,
		output clear_mask,
		output clear
	);
endinterface

//--- gpio_in_capture.sv
// Input pin synchronizer with edge detect and sticky change flags
module gpio_in_capture
	import gpio_io_pkg::*;
(
	input  logic           rvx_port_06,
	input  logic           rvx_port_03,
	input  gpio_in_t       gpio_in,
	gpio_status_if.capture status
);

	// ************************************************************
	// Synchronizer
	// ************************************************************
	// First stage may go metastable
	gpio_in_t sync_1;
	// Second stage is the value seen by IN
	gpio_in_t sync_2;
	// Synchronized value one cycle back
	gpio_in_t sync_prev;

	// Sticky flags and this cycle's set and clear terms
	gpio_in_t change_q;
	gpio_in_t in_edge;
	gpio_in_t clr_bits;

	// Stages reset low
	// Pins high at reset show up as changes a few cycles later
	always_ff @(posedge rvx_port_06, negedge rvx_port_03)
	begin
		if (!rvx_port_03)
		begin
			sync_1    <= '0;
			sync_2    <= '0;
			sync_prev <= '0;
		end
		else
		begin
			sync_1    <= gpio_in;
			sync_2    <= sync_1;
			sync_prev <= sync_2;
		end
	end

	// ************************************************************
	// Change capture
	// ************************************************************
	// Any bit that moved since last cycle
	assign in_edge  = sync_2 ^ sync_prev;

	// Mask applies only while the strobe is up
	assign clr_bits = status.clear ? status.clear_mask : '0;

	// Clear first and then set
	// A new edge in the clear cycle keeps its flag
	always_ff @(posedge rvx_port_06, negedge rvx_port_03)
	begin
		if (!rvx_port_03)
			change_q <= '0;
		else
			change_q <= (change_q & ~clr_bits) | in_edge;
	end

	// Present state to the bus side
	assign status.in_value = sync_2;
	assign status.change   = change_q;

endmodule

//--- gpio_wb_slave.sv
// Wishbone classic slave for the GPIO registers with read mux and interrupt combine
`include "gpio_consts.svh"

module gpio_wb_slave
	import gpio_bus_pkg::*;
	import gpio_io_pkg::*;
(
	input  logic          rvx_port_06,
	input  logic          rvx_port_03,

	// Wishbone classic slave
	input  logic          wb_cyc,
	input  logic          wb_stb,
	input  logic          wb_we,
	input  wb_adr_t       wb_adr,
	input  wb_dat_t       wb_dat_w,
	output wb_dat_t       wb_dat_r,
	output logic          wb_ack,

	// Pins and interrupt
	output gpio_out_t     gpio_out,
	output logic          irq,

	// Link to the input capture block
	gpio_status_if.host   status
);

	// ************************************************************
	// Request decode
	// ************************************************************
	// New access sampled this cycle
	logic      req;
	logic      wr_req;
	logic      rd_req;
	// Word select from address bits 3 to 2
	gpio_reg_e reg_sel;

	// Register contents
	gpio_out_t out_q;
	gpio_in_t  irq_en_q;
	// Selected source before the read register
	wb_dat_t   rd_value;

	// Ack low gates the cycle in which the ack is already out
	// so one request gives one ack
	assign req     = wb_cyc && wb_stb && !wb_ack;
	assign wr_req  = req && wb_we;
	assign rd_req  = req && !wb_we;
	assign reg_sel = gpio_reg_e'(wb_adr[3:2]);

	// ************************************************************
	// Acknowledge
	// ************************************************************
	// Registered one cycle after the request
	always_ff @(posedge rvx_port_06, negedge rvx_port_03)
	begin
		if (!rvx_port_03)
			wb_ack <= 1'b0;
		else
			wb_ack <= req;
	end

	// ************************************************************
	// Writable registers
	// ************************************************************
	// Writes land on the edge that raises the ack
	// Writes to IN fall through without effect
	always_ff @(posedge rvx_port_06, negedge rvx_port_03)
	begin
		if (!rvx_port_03)
		begin
			out_q    <= '0;
			irq_en_q <= '0;
		end
		else if (wr_req)
		begin
			if (reg_sel == REG_OUT)
				out_q <= wb_dat_w[`GPIO_OUT_W-1:0];
			if (reg_sel == REG_IRQ_EN)
				irq_en_q <= wb_dat_w[`GPIO_IN_W-1:0];
		end
	end

	assign gpio_out = out_q;

	// Write-one-to-clear on CHANGE
	// Strobe lasts exactly the request cycle
	assign status.clear      = wr_req && (reg_sel == REG_CHANGE);
	assign status.clear_mask = wb_dat_w[`GPIO_IN_W-1:0];

	// ************************************************************
	// Read path
	// ************************************************************
	// Narrow registers zero extended to the bus word
	always_comb
	begin
		unique case (reg_sel)
			REG_OUT:    rd_value = wb_dat_t'(out_q);
			REG_IN:     rd_value = wb_dat_t'(status.in_value);
			REG_CHANGE: rd_value = wb_dat_t'(status.change);
			REG_IRQ_EN: rd_value = wb_dat_t'(irq_en_q);
			default:    rd_value = '0;
		endcase
	end

	// Read data held from the ack cycle on
	always_ff @(posedge rvx_port_06)
	begin
		if (rd_req)
			wb_dat_r <= rd_value;
	end

	// ************************************************************
	// Interrupt
	// ************************************************************
	// Any enabled change flag raises the line
	assign irq = |(status.change & irq_en_q);

endmodule

//--- gpio_top.sv
// GPIO block top joining the Wishbone slave and the input capture logic
module gpio_top
	import gpio_bus_pkg::*;
	import gpio_io_pkg::*;
(
	input  logic      rvx_port_06,
	input  logic      rvx_port_03,

	// Wishbone classic slave port
	input  logic      wb_cyc,
	input  logic      wb_stb,
	input  logic      wb_we,
	input  wb_adr_t   wb_adr,
	input  wb_dat_t   wb_dat_w,
	output wb_dat_t   wb_dat_r,
	output logic      wb_ack,

	// Pins
	input  gpio_in_t  gpio_in,
	output gpio_out_t gpio_out,

	// Change interrupt
	output logic      irq
);

	// Pin state and clear requests between the two blocks
	gpio_status_if u_status ();

	// Synchronizer and sticky change flags
	gpio_in_capture u_capture
	(
		.rvx_port_06 (rvx_port_06),
		.rvx_port_03 (rvx_port_03),
		.gpio_in     (gpio_in),
		.status      (u_status.capture)
	);

	// Register file on the bus
	gpio_wb_slave u_slave
	(
		.rvx_port_06 (rvx_port_06),
		.rvx_port_03 (rvx_port_03),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.gpio_out    (gpio_out),
		.irq         (irq),
		.status      (u_status.host)
	);

endmodule

//--- gpio_assert.sv
// Wishbone handshake and interrupt consistency checks bound into the GPIO slave
`include "gpio_consts.svh"

module gpio_assert
(
	input logic                   rvx_port_06,
	input logic                   rvx_port_03,
	input logic                   wb_cyc,
	input logic                   wb_stb,
	input logic                   wb_we,
	input logic [`GPIO_ADR_W-1:0] wb_adr,
	input logic [`GPIO_DAT_W-1:0] wb_dat_w,
	input logic                   wb_ack,
	input logic                   irq,
	input logic [`GPIO_IN_W-1:0]  change
);

	// IRQ_EN as the bus master wrote it
	logic [`GPIO_IN_W-1:0] irq_en_seen;
	// Sampled write request to IRQ_EN
	logic                  en_write;

	// A request counts when the ack is not already out
	assign en_write = wb_cyc && wb_stb && wb_we && !wb_ack
		&& (wb_adr[3:2] == 2'(`GPIO_OFS_IRQ_EN >> 2));

	always_ff @(posedge rvx_port_06, negedge rvx_port_03)
	begin
		if (!rvx_port_03)
			irq_en_seen <= '0;
		else if (en_write)
			irq_en_seen <= wb_dat_w[`GPIO_IN_W-1:0];
	end

	// ************************************************************
	// Handshake
	// ************************************************************
	// Registered ack lasts one cycle
	ack_single: assert property (@(posedge rvx_port_06) disable iff (!rvx_port_03)
		wb_ack |=> !wb_ack)
		else $error("wb_ack stayed high for two cycles");

	// Ack only follows a sampled request
	ack_after_req: assert property (@(posedge rvx_port_06) disable iff (!rvx_port_03)
		wb_ack |-> $past(wb_cyc && wb_stb))
		else $error("wb_ack rose without wb_cyc and wb_stb in the cycle before");

	// ************************************************************
	// Interrupt
	// ************************************************************
	// Line is the OR of the flags under the mask written over the bus
	irq_match: assert property (@(posedge rvx_port_06) disable iff (!rvx_port_03)
		irq == |(change & irq_en_seen))
		else $error("irq differs from the change flags masked by the written IRQ_EN");

endmodule

bind gpio_wb_slave gpio_assert u_assert
(
	.rvx_port_06 (rvx_port_06),
	.rvx_port_03 (rvx_port_03),
	.wb_cyc      (wb_cyc),
	.wb_stb      (wb_stb),
	.wb_we       (wb_we),
	.wb_adr      (wb_adr),
	.wb_dat_w    (wb_dat_w),
	.wb_ack      (wb_ack),
	.irq         (irq),
	.change      (status.change)
);

//--- gpio_tb.sv
// Table driven testbench for the GPIO block over its Wishbone port
`include "gpio_consts.svh"

module gpio_tb
	import gpio_bus_pkg::*;
	import gpio_io_pkg::*;
();

	localparam int DRIVE_DLY   = 10;
	localparam int ACK_TIMEOUT = 20;
	localparam int POLL_LIMIT  = 20;
	localparam int MAX_ENTRIES = 40;
	// Table operations
	localparam int OP_WR  = 0;
	localparam int OP_RD  = 1;
	localparam int OP_PIN = 2;

	logic      rvx_port_06;
	logic      rvx_port_03;
	logic      wb_cyc;
	logic      wb_stb;
	logic      wb_we;
	wb_adr_t   wb_adr;
	wb_dat_t   wb_dat_w;
	wb_dat_t   wb_dat_r;
	logic      wb_ack;
	gpio_in_t  gpio_in;
	gpio_out_t gpio_out;
	logic      irq;

	int     errors;
	integer seed;
	int     n_entries;

	// ************************************************************
	// Stimulus table
	// ************************************************************
	string    t_name [MAX_ENTRIES];
	int       t_op   [MAX_ENTRIES];
	wb_adr_t  t_adr  [MAX_ENTRIES];
	wb_dat_t  t_wdat [MAX_ENTRIES];
	gpio_in_t t_pin  [MAX_ENTRIES];
	wb_dat_t  t_exp  [MAX_ENTRIES];
	logic     t_irq  [MAX_ENTRIES];

	gpio_top u_gpio_top
	(
		.rvx_port_06 (rvx_port_06),
		.rvx_port_03 (rvx_port_03),
		.wb_cyc      (wb_cyc),
		.wb_stb      (wb_stb),
		.wb_we       (wb_we),
		.wb_adr      (wb_adr),
		.wb_dat_w    (wb_dat_w),
		.wb_dat_r    (wb_dat_r),
		.wb_ack      (wb_ack),
		.gpio_in     (gpio_in),
		.gpio_out    (gpio_out),
		.irq         (irq)
	);

	initial
	begin
		rvx_port_06 = 1'b0;
		forever #50 rvx_port_06 = ~rvx_port_06;
	end

	function automatic void add_entry(input string name, input int op, input wb_adr_t adr,
		input wb_dat_t wdat, input gpio_in_t pin, input wb_dat_t exp, input logic exp_irq);
		t_name[n_entries] = name;
		t_op[n_entries]   = op;
		t_adr[n_entries]  = adr;
		t_wdat[n_entries] = wdat;
		t_pin[n_entries]  = pin;
		t_exp[n_entries]  = exp;
		t_irq[n_entries]  = exp_irq;
		n_entries++;
	endfunction

	// Expected values follow the register rules on a small model
	task automatic build_table();
		logic [31:0] r1;
		logic [31:0] r2;
		gpio_in_t    p1;
		gpio_in_t    p2;
		gpio_in_t    m;
		gpio_in_t    en;
		gpio_in_t    chg;
		r1 = $random(seed);
		r2 = $random(seed);
		add_entry("clr_change_init", OP_WR, `GPIO_OFS_CHANGE, 32'hffff, '0, '0, 1'b0);
		add_entry("rd_out_reset", OP_RD, `GPIO_OFS_OUT, '0, '0, '0, 1'b0);
		add_entry("rd_irq_en_reset", OP_RD, `GPIO_OFS_IRQ_EN, '0, '0, '0, 1'b0);
		add_entry("rd_change_reset", OP_RD, `GPIO_OFS_CHANGE, '0, '0, '0, 1'b0);
		add_entry("wr_out_1", OP_WR, `GPIO_OFS_OUT, r1, '0, {16'h0, r1[15:0]}, 1'b0);
		add_entry("rd_out_1", OP_RD, `GPIO_OFS_OUT, '0, '0, {16'h0, r1[15:0]}, 1'b0);
		add_entry("wr_out_2", OP_WR, `GPIO_OFS_OUT, r2, '0, {16'h0, r2[15:0]}, 1'b0);
		add_entry("rd_out_2", OP_RD, `GPIO_OFS_OUT, '0, '0, {16'h0, r2[15:0]}, 1'b0);
		add_entry("rd_in_before", OP_RD, `GPIO_OFS_IN, '0, '0, '0, 1'b0);
		add_entry("wr_in_ignored", OP_WR, `GPIO_OFS_IN, $random(seed), '0, '0, 1'b0);
		add_entry("rd_in_after_wr", OP_RD, `GPIO_OFS_IN, '0, '0, '0, 1'b0);
		// Pins from zero to p1 flag every set bit of p1
		p1 = $random(seed);
		add_entry("pin_1", OP_PIN, '0, '0, p1, {16'h0, p1}, 1'b0);
		add_entry("rd_change_1", OP_RD, `GPIO_OFS_CHANGE, '0, '0, {16'h0, p1}, 1'b0);
		add_entry("clr_change_all", OP_WR, `GPIO_OFS_CHANGE, 32'hffff, '0, '0, 1'b0);
		add_entry("rd_change_clr", OP_RD, `GPIO_OFS_CHANGE, '0, '0, '0, 1'b0);
		// Bits 15 and 0 always toggle so some flags survive the mask
		p2  = p1 ^ (16'($random(seed)) | 16'h8001);
		chg = p1 ^ p2;
		add_entry("pin_2", OP_PIN, '0, '0, p2, {16'h0, p2}, 1'b0);
		add_entry("rd_change_xor", OP_RD, `GPIO_OFS_CHANGE, '0, '0, {16'h0, chg}, 1'b0);
		m   = 16'($random(seed)) & 16'h7ffe;
		chg = chg & ~m;
		add_entry("clr_change_mask", OP_WR, `GPIO_OFS_CHANGE, {16'h0, m}, '0, '0, 1'b0);
		add_entry("rd_change_mask", OP_RD, `GPIO_OFS_CHANGE, '0, '0, {16'h0, chg}, 1'b0);
		// Mask that misses every flag keeps irq low
		en = ~chg;
		add_entry("wr_irq_en_off", OP_WR, `GPIO_OFS_IRQ_EN, {16'h0, en}, '0, '0, |(chg & en));
		add_entry("rd_irq_en_off", OP_RD, `GPIO_OFS_IRQ_EN, '0, '0, {16'h0, en}, |(chg & en));
		en = 16'($random(seed)) | 16'h8000;
		add_entry("wr_irq_en_on", OP_WR, `GPIO_OFS_IRQ_EN, {16'h0, en}, '0, '0, |(chg & en));
		add_entry("rd_irq_en_on", OP_RD, `GPIO_OFS_IRQ_EN, '0, '0, {16'h0, en}, |(chg & en));
		// Clearing the flags drops the line
		add_entry("clr_change_irq", OP_WR, `GPIO_OFS_CHANGE, {16'h0, chg}, '0, '0, 1'b0);
		add_entry("rd_change_irq", OP_RD, `GPIO_OFS_CHANGE, '0, '0, '0, 1'b0);
		// A new edge on bit 15 raises it again
		add_entry("pin_3", OP_PIN, '0, '0, p2 ^ 16'h8000, {16'h0, p2 ^ 16'h8000}, 1'b1);
		add_entry("wr_irq_en_zero", OP_WR, `GPIO_OFS_IRQ_EN, '0, '0, '0, 1'b0);
		add_entry("rd_change_kept", OP_RD, `GPIO_OFS_CHANGE, '0, '0, 32'h8000, 1'b0);
	endtask

	// ************************************************************
	// Bus tasks
	// ************************************************************
	task automatic check_value(input string name, input wb_dat_t exp, input wb_dat_t act);
		assert (act === exp)
		else
		begin
			errors++;
			$display("Error %s expected %h actual %h", name, exp, act);
		end
	endtask

	// Sample the ack a drive delay after each edge
	task automatic wait_ack(output logic ok);
		int cycles;
		cycles = 0;
		ok = 1'b0;
		while (!ok && cycles < ACK_TIMEOUT)
		begin
			@(posedge rvx_port_06);
			#DRIVE_DLY;
			ok = wb_ack;
			cycles++;
		end
	endtask

	task automatic wb_write(input wb_adr_t adr, input wb_dat_t dat);
		logic ok;
		@(posedge rvx_port_06);
		#DRIVE_DLY;
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = 1'b1;
		wb_adr   = adr;
		wb_dat_w = dat;
		wait_ack(ok);
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
		if (!ok)
		begin
			errors++;
			$display("No wb_ack within %0d cycles for write to address %h", ACK_TIMEOUT, adr);
		end
	endtask

	task automatic wb_read(input wb_adr_t adr, output wb_dat_t dat);
		logic ok;
		@(posedge rvx_port_06);
		#DRIVE_DLY;
		wb_cyc = 1'b1;
		wb_stb = 1'b1;
		wb_we  = 1'b0;
		wb_adr = adr;
		wait_ack(ok);
		// Data is valid while the ack is high
		dat    = ok ? wb_dat_r : 'x;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		if (!ok)
		begin
			errors++;
			$display("No wb_ack within %0d cycles for read from address %h", ACK_TIMEOUT, adr);
		end
	endtask

	// Read IN until it shows the new pins or the limit runs out
	task automatic poll_in(input string name, input wb_dat_t exp);
		wb_dat_t dat;
		int      polls;
		polls = 0;
		dat   = 'x;
		while (dat !== exp && polls < POLL_LIMIT)
		begin
			wb_read(`GPIO_OFS_IN, dat);
			polls++;
		end
		check_value(name, exp, dat);
	endtask

	task automatic run_entry(input int i);
		wb_dat_t dat;
		case (t_op[i])
			OP_WR:
			begin
				wb_write(t_adr[i], t_wdat[i]);
				if (t_adr[i] == `GPIO_OFS_OUT)
					check_value(t_name[i], t_exp[i], wb_dat_t'(gpio_out));
			end
			OP_RD:
			begin
				wb_read(t_adr[i], dat);
				check_value(t_name[i], t_exp[i], dat);
			end
			default:
			begin
				gpio_in = t_pin[i];
				poll_in(t_name[i], t_exp[i]);
			end
		endcase
		check_value({t_name[i], "_irq"}, wb_dat_t'(t_irq[i]), wb_dat_t'(irq));
	endtask

	// ************************************************************
	// Main sequence
	// ************************************************************
	initial
	begin
		seed        = 32'haa0d3ceb;
		errors      = 0;
		n_entries   = 0;
		rvx_port_03 = 1'b0;
		wb_cyc      = 1'b0;
		wb_stb      = 1'b0;
		wb_we       = 1'b0;
		wb_adr      = '0;
		wb_dat_w    = '0;
		gpio_in     = '0;
		build_table();
		repeat (10) @(posedge rvx_port_06);
		#DRIVE_DLY;
		rvx_port_03 = 1'b1;
		check_value("gpio_out_reset", '0, wb_dat_t'(gpio_out));
		check_value("irq_reset", '0, wb_dat_t'(irq));
		for (int i = 0; i < n_entries; i++)
			run_entry(i);
		$display("Run finished with %0d errors", errors);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

//--- vlog.f
+incdir+.
gpio_bus_pkg.sv
gpio_io_pkg.sv
gpio_status_if.sv
gpio_in_capture.sv
gpio_wb_slave.sv
gpio_top.sv
gpio_assert.sv
gpio_tb.sv
